// File: source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // 16 direct-mapped lines of one word each
    localparam int INDEX_W = 4;
    localparam int LINES = 2 ** INDEX_W;

    // page-table entry flag positions
    localparam int PTE_A_BIT = 6;
    localparam int PTE_D_BIT = 7;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef struct packed {
        logic  valid;
        logic  wen;
        addr_t addr;
        word_t wdata;
        logic  pte_a;
        logic  pte_d;
    } cache_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
        logic  error;
    } cache_resp_t;

    typedef struct packed {
        logic  valid;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
        logic  error;
    } bus_resp_t;

    typedef struct packed {
        logic   en;
        index_t index;
        addr_t  addr;
        logic   valid;
        logic   dirty;
    } tag_update_t;

    typedef struct packed {
        logic   en;
        index_t index;
        word_t  data;
        logic   set_a;
        logic   set_d;
    } word_update_t;

    // word address bits select the line
    function automatic index_t index_of(input addr_t addr);
        return addr[INDEX_W+1:2];
    endfunction

endpackage

`default_nettype wire

// File: source/dcache_tag_store.sv
`default_nettype none

module dcache_tag_store (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  dcache_pkg::addr_t       lookup_addr,
    output logic                          hit,
    output logic                          victim_dirty,
    output dcache_pkg::addr_t             victim_addr,
    input  wire  dcache_pkg::tag_update_t update,
    input  wire  dcache_pkg::index_t      walk_index,
    output logic                          walk_dirty,
    output dcache_pkg::addr_t             walk_addr,
    input  wire                           dirty_inc,
    input  wire                           dirty_dec,
    output logic                          dirty_count_zero
);

    dcache_pkg::addr_t tags [dcache_pkg::LINES];
    logic [dcache_pkg::LINES-1:0] valid_bits;
    logic [dcache_pkg::LINES-1:0] dirty_bits;
    logic [dcache_pkg::INDEX_W:0] dirty_count;
    dcache_pkg::index_t lookup_index;

    assign lookup_index = dcache_pkg::index_of(lookup_addr);

    // full address is kept, so the compare covers the index bits too
    assign hit = valid_bits[lookup_index] && (tags[lookup_index] == lookup_addr);
    assign victim_dirty = valid_bits[lookup_index] && dirty_bits[lookup_index];
    assign victim_addr = tags[lookup_index];

    // flush walk view
    assign walk_dirty = valid_bits[walk_index] && dirty_bits[walk_index];
    assign walk_addr = tags[walk_index];

    assign dirty_count_zero = (dirty_count == '0);

    always_ff @(posedge clk) begin
        if (update.en) begin
            tags[update.index] <= update.addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (update.en) begin
            valid_bits[update.index] <= update.valid;
            dirty_bits[update.index] <= update.dirty;
        end
    end

    // running count of dirty lines drives the clean output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dirty_count <= '0;
        end else begin
            case ({dirty_inc, dirty_dec})
                2'b10: dirty_count <= dirty_count + (dcache_pkg::INDEX_W + 1)'(1);
                2'b01: dirty_count <= dirty_count - (dcache_pkg::INDEX_W + 1)'(1);
                default: dirty_count <= dirty_count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_data_store.sv
`default_nettype none

module dcache_data_store (
    input  wire                            clk,
    input  wire  dcache_pkg::index_t       rd_index,
    input  wire  dcache_pkg::word_update_t update,
    output dcache_pkg::word_t              rdata
);

    dcache_pkg::word_t words [dcache_pkg::LINES];
    dcache_pkg::word_t base;
    dcache_pkg::word_t merged;

    // page-walk updates OR the flags into the resident word,
    // plain writes take the new data
    always_comb begin
        if (update.set_a || update.set_d) begin
            base = words[update.index];
        end else begin
            base = update.data;
        end
        merged = base;
        merged[dcache_pkg::PTE_A_BIT] = base[dcache_pkg::PTE_A_BIT] | update.set_a;
        merged[dcache_pkg::PTE_D_BIT] = base[dcache_pkg::PTE_D_BIT] | update.set_d;
    end

    always_ff @(posedge clk) begin
        if (update.en) begin
            words[update.index] <= merged;
        end
    end

    // response word also forwards a same-cycle write so it matches the array
    always_ff @(posedge clk) begin
        if (update.en && (update.index == rd_index)) begin
            rdata <= merged;
        end else begin
            rdata <= words[rd_index];
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire  dcache_pkg::cache_req_t    req,
    output logic                            req_ready,
    output logic                            resp_valid,
    output logic                            resp_error,
    output dcache_pkg::bus_req_t            bus_req,
    input  wire                             bus_ready,
    input  wire  dcache_pkg::bus_resp_t     bus_resp,
    input  wire                             flush,
    output logic                            clean,
    input  wire                             hit,
    input  wire                             victim_dirty,
    input  wire  dcache_pkg::addr_t         victim_addr,
    input  wire                             dirty_count_zero,
    input  wire                             walk_dirty,
    input  wire  dcache_pkg::addr_t         walk_addr,
    output dcache_pkg::tag_update_t         tag_update,
    output dcache_pkg::index_t              walk_index,
    output logic                            dirty_inc,
    output logic                            dirty_dec,
    output dcache_pkg::word_update_t        word_update,
    output dcache_pkg::index_t              rd_index,
    input  wire  dcache_pkg::word_t         rdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_REQ,
        S_READ_WAIT,
        S_RESPOND,
        S_WB_REQ,
        S_WALK_CHECK,
        S_WALK_WRITE
    } state_t;

    state_t state_q;
    state_t state_d;
    dcache_pkg::cache_req_t lat_q;
    dcache_pkg::addr_t wb_addr_q;
    dcache_pkg::index_t walk_idx_q;
    dcache_pkg::index_t rd_idx_q;
    dcache_pkg::index_t req_index;
    dcache_pkg::index_t lat_index;
    logic flush_pending_q;
    logic start_flush;
    logic accept;
    logic fresh;
    logic word_differs;
    logic pte_change;
    logic fill_change;

    function automatic dcache_pkg::tag_update_t tag_cmd(input dcache_pkg::index_t index,
                                                        input dcache_pkg::addr_t addr,
                                                        input logic valid,
                                                        input logic dirty);
        dcache_pkg::tag_update_t cmd;
        cmd.en = 1'b1;
        cmd.index = index;
        cmd.addr = addr;
        cmd.valid = valid;
        cmd.dirty = dirty;
        return cmd;
    endfunction

    function automatic dcache_pkg::word_update_t word_cmd(input dcache_pkg::index_t index,
                                                          input dcache_pkg::word_t data,
                                                          input logic set_a,
                                                          input logic set_d);
        dcache_pkg::word_update_t cmd;
        cmd.en = 1'b1;
        cmd.index = index;
        cmd.data = data;
        cmd.set_a = set_a;
        cmd.set_d = set_d;
        return cmd;
    endfunction

    assign req_index = dcache_pkg::index_of(req.addr);
    assign lat_index = dcache_pkg::index_of(lat_q.addr);

    // a pending flush wins over a new request at idle
    assign start_flush = flush || flush_pending_q;
    assign req_ready = (state_q == S_IDLE) && !start_flush;
    assign accept = req_ready && req.valid;
    assign clean = dirty_count_zero && !flush_pending_q;
    assign walk_index = walk_idx_q;

    // rdata holds the word at last cycle's rd_index; otherwise assume a change
    assign fresh = (rd_idx_q == req_index);
    assign word_differs = !fresh || (rdata != req.wdata);
    assign pte_change = req.pte_a && (!fresh || !rdata[dcache_pkg::PTE_A_BIT]
                        || (req.pte_d && !rdata[dcache_pkg::PTE_D_BIT]));
    // in respond the filled word is already in rdata
    assign fill_change = lat_q.pte_a && !resp_error && (!rdata[dcache_pkg::PTE_A_BIT]
                         || (lat_q.pte_d && !rdata[dcache_pkg::PTE_D_BIT]));

    always_comb begin
        case (state_q)
            S_IDLE: rd_index = req_index;
            S_WALK_CHECK, S_WALK_WRITE: rd_index = walk_idx_q;
            default: rd_index = lat_index;
        endcase
    end

    // write data always comes from the data store's read register
    always_comb begin
        bus_req.valid = (state_q == S_READ_REQ) || (state_q == S_WB_REQ)
                        || (state_q == S_WALK_WRITE);
        bus_req.wen = (state_q != S_READ_REQ);
        bus_req.wdata = rdata;
        case (state_q)
            S_READ_REQ: bus_req.addr = lat_q.addr;
            S_WB_REQ: bus_req.addr = wb_addr_q;
            default: bus_req.addr = walk_addr;
        endcase
    end

    always_comb begin
        state_d = state_q;
        tag_update = '0;
        word_update = '0;
        dirty_inc = 1'b0;
        dirty_dec = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (start_flush) begin
                    state_d = S_WALK_CHECK;
                end else if (req.valid) begin
                    if (hit && req.wen) begin
                        word_update = word_cmd(req_index, req.wdata, 1'b0, 1'b0);
                        if (word_differs && !victim_dirty) begin
                            tag_update = tag_cmd(req_index, req.addr, 1'b1, 1'b1);
                            dirty_inc = 1'b1;
                        end
                    end else if (hit) begin
                        if (pte_change) begin
                            word_update = word_cmd(req_index, rdata, 1'b1, req.pte_d);
                            tag_update = tag_cmd(req_index, req.addr, 1'b1, 1'b1);
                            dirty_inc = !victim_dirty;
                        end
                    end else if (victim_dirty) begin
                        state_d = S_WB_REQ;
                    end else if (req.wen) begin
                        // allocate without a fetch
                        word_update = word_cmd(req_index, req.wdata, 1'b0, 1'b0);
                        tag_update = tag_cmd(req_index, req.addr, 1'b1, 1'b1);
                        dirty_inc = 1'b1;
                    end else begin
                        state_d = S_READ_REQ;
                    end
                end
            end
            S_READ_REQ: begin
                if (bus_ready) begin
                    state_d = S_READ_WAIT;
                end
            end
            S_READ_WAIT: begin
                if (bus_resp.valid) begin
                    // an error leaves the line invalid
                    tag_update = tag_cmd(lat_index, lat_q.addr, !bus_resp.error, 1'b0);
                    if (!bus_resp.error) begin
                        word_update = word_cmd(lat_index, bus_resp.rdata, 1'b0, 1'b0);
                    end
                    state_d = S_RESPOND;
                end
            end
            S_RESPOND: begin
                if (fill_change) begin
                    word_update = word_cmd(lat_index, rdata, 1'b1, lat_q.pte_d);
                    tag_update = tag_cmd(lat_index, lat_q.addr, 1'b1, 1'b1);
                    dirty_inc = 1'b1;
                end
                state_d = S_IDLE;
            end
            S_WB_REQ: begin
                if (bus_ready && lat_q.wen) begin
                    // line stays dirty, so the count is unchanged
                    word_update = word_cmd(lat_index, lat_q.wdata, 1'b0, 1'b0);
                    tag_update = tag_cmd(lat_index, lat_q.addr, 1'b1, 1'b1);
                    state_d = S_IDLE;
                end else if (bus_ready) begin
                    tag_update = tag_cmd(lat_index, lat_q.addr, 1'b0, 1'b0);
                    dirty_dec = 1'b1;
                    state_d = S_READ_REQ;
                end
            end
            S_WALK_CHECK: begin
                if (dirty_count_zero) begin
                    state_d = S_IDLE;
                end else if (walk_dirty) begin
                    state_d = S_WALK_WRITE;
                end
            end
            S_WALK_WRITE: begin
                if (bus_ready) begin
                    tag_update = tag_cmd(walk_idx_q, walk_addr, 1'b1, 1'b0);
                    dirty_dec = 1'b1;
                    state_d = S_WALK_CHECK;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            walk_idx_q <= '0;
            flush_pending_q <= 1'b0;
            resp_valid <= 1'b0;
            resp_error <= 1'b0;
        end else begin
            state_q <= state_d;
            // hit or clean write miss, read fill, write after write-back
            resp_valid <= (accept && (state_d == S_IDLE)) || (state_q == S_RESPOND)
                          || ((state_q == S_WB_REQ) && bus_ready && lat_q.wen);
            if (accept) begin
                resp_error <= 1'b0;
            end else if ((state_q == S_READ_WAIT) && bus_resp.valid) begin
                resp_error <= bus_resp.error;
            end
            if ((state_q == S_IDLE) && start_flush) begin
                flush_pending_q <= 1'b0;
            end else if (flush && (state_q != S_WALK_CHECK) && (state_q != S_WALK_WRITE)) begin
                flush_pending_q <= 1'b1;
            end
            // walk index moves on after a clean line or a finished write
            if ((state_q == S_IDLE) && start_flush) begin
                walk_idx_q <= '0;
            end else if ((state_q == S_WALK_CHECK) && !dirty_count_zero && !walk_dirty) begin
                walk_idx_q <= walk_idx_q + 1'b1;
            end else if ((state_q == S_WALK_WRITE) && bus_ready) begin
                walk_idx_q <= walk_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_idx_q <= rd_index;
        if (accept) begin
            lat_q <= req;
            wb_addr_q <= victim_addr;
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_top.sv
`default_nettype none

module dcache_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  dcache_pkg::cache_req_t req,
    output logic                         req_ready,
    output dcache_pkg::cache_resp_t      resp,
    output dcache_pkg::bus_req_t         bus_req,
    input  wire                          bus_ready,
    input  wire  dcache_pkg::bus_resp_t  bus_resp,
    input  wire                          flush,
    output logic                         clean
);

    logic hit;
    logic victim_dirty;
    dcache_pkg::addr_t victim_addr;
    logic walk_dirty;
    dcache_pkg::addr_t walk_addr;
    dcache_pkg::index_t walk_index;
    logic dirty_inc;
    logic dirty_dec;
    logic dirty_count_zero;
    dcache_pkg::tag_update_t tag_update;
    dcache_pkg::word_update_t word_update;
    dcache_pkg::index_t rd_index;
    dcache_pkg::word_t rdata;
    logic resp_valid;
    logic resp_error;

    assign resp = '{valid: resp_valid, rdata: rdata, error: resp_error};

    // lookup only matters at idle, where the port address is the request
    dcache_tag_store u_tag_store (
        .clk              (clk),
        .rst_n            (rst_n),
        .lookup_addr      (req.addr),
        .hit              (hit),
        .victim_dirty     (victim_dirty),
        .victim_addr      (victim_addr),
        .update           (tag_update),
        .walk_index       (walk_index),
        .walk_dirty       (walk_dirty),
        .walk_addr        (walk_addr),
        .dirty_inc        (dirty_inc),
        .dirty_dec        (dirty_dec),
        .dirty_count_zero (dirty_count_zero)
    );

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .req              (req),
        .req_ready        (req_ready),
        .resp_valid       (resp_valid),
        .resp_error       (resp_error),
        .bus_req          (bus_req),
        .bus_ready        (bus_ready),
        .bus_resp         (bus_resp),
        .flush            (flush),
        .clean            (clean),
        .hit              (hit),
        .victim_dirty     (victim_dirty),
        .victim_addr      (victim_addr),
        .dirty_count_zero (dirty_count_zero),
        .walk_dirty       (walk_dirty),
        .walk_addr        (walk_addr),
        .tag_update       (tag_update),
        .walk_index       (walk_index),
        .dirty_inc        (dirty_inc),
        .dirty_dec        (dirty_dec),
        .word_update      (word_update),
        .rd_index         (rd_index),
        .rdata            (rdata)
    );

    // read register feeds both the response and write-back data
    dcache_data_store u_data_store (
        .clk      (clk),
        .rd_index (rd_index),
        .update   (word_update),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// File: dv/bus_memory.sv
`default_nettype none

module bus_memory (
    input  wire                         clk,
    input  wire  dcache_pkg::bus_req_t  bus_req,
    output logic                        bus_ready,
    output dcache_pkg::bus_resp_t       bus_resp,
    output int                          read_count,
    output int                          write_count,
    output dcache_pkg::bus_req_t        last_write
);

    dcache_pkg::word_t mem [256];
    dcache_pkg::bus_req_t taken;
    int unsigned delay;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = i ^ 32'h5a5a_0000;
        end
        bus_ready = 1'b0;
        bus_resp = '0;
        read_count = 0;
        write_count = 0;
        last_write = '0;
        // one fixed seed for the ready delays
        void'($urandom(32'ha76b_8bf6));
        forever begin
            @(posedge clk);
            #10;
            if (bus_req.valid) begin
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #10;
                end
                // request fields are held until the transfer
                taken = bus_req;
                bus_ready = 1'b1;
                @(posedge clk);
                #10;
                bus_ready = 1'b0;
                if (taken.wen) begin
                    mem[taken.addr[9:2]] = taken.wdata;
                    last_write = taken;
                    write_count++;
                end else begin
                    read_count++;
                    @(posedge clk);
                    #10;
                    bus_resp.valid = 1'b1;
                    bus_resp.rdata = mem[taken.addr[9:2]];
                    // top 16th of the address space answers with error
                    bus_resp.error = (taken.addr[31:28] == 4'hf);
                    @(posedge clk);
                    #10;
                    bus_resp = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_dcache.sv
`default_nettype none

module tb_dcache;

    logic clk;
    logic rst_n;
    dcache_pkg::cache_req_t req;
    logic req_ready;
    dcache_pkg::cache_resp_t resp;
    dcache_pkg::bus_req_t bus_req;
    logic bus_ready;
    dcache_pkg::bus_resp_t bus_resp;
    logic flush;
    logic clean;
    int read_count;
    int write_count;
    dcache_pkg::bus_req_t last_write;
    dcache_pkg::word_t shadow [256];
    dcache_pkg::cache_resp_t seen;
    int latency;
    int value_errors;
    int timeout_errors;

    always #50 clk = ~clk;

    dcache_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_ready (req_ready),
        .resp      (resp),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_resp  (bus_resp),
        .flush     (flush),
        .clean     (clean)
    );

    bus_memory bus_mem (
        .clk         (clk),
        .bus_req     (bus_req),
        .bus_ready   (bus_ready),
        .bus_resp    (bus_resp),
        .read_count  (read_count),
        .write_count (write_count),
        .last_write  (last_write)
    );

    // initial memory contents are the word address xor a fixed mark
    function automatic dcache_pkg::word_t mem_pattern(input dcache_pkg::addr_t addr);
        return {24'h0, addr[9:2]} ^ 32'h5a5a_0000;
    endfunction

    function automatic dcache_pkg::cache_resp_t make_resp(input dcache_pkg::word_t rdata,
                                                          input logic error);
        dcache_pkg::cache_resp_t r;
        r.valid = 1'b1;
        r.rdata = rdata;
        r.error = error;
        return r;
    endfunction

    task automatic check_resp(input string name, input dcache_pkg::cache_resp_t got,
                              input dcache_pkg::cache_resp_t exp, input logic with_data);
        dcache_pkg::cache_resp_t want;
        want = exp;
        // writes and bus errors carry no defined data
        if (!with_data) begin
            want.rdata = got.rdata;
        end
        if (got !== want) begin
            $display("FAILED %s: got %h, expected %h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_bus_write(input dcache_pkg::bus_req_t got,
                                   input dcache_pkg::bus_req_t exp);
        if (got !== exp) begin
            $display("FAILED bus write: got %h, expected %h", got, exp);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // one request waits for acceptance and then for the response pulse
    task automatic access(input dcache_pkg::addr_t addr, input logic wen,
                          input dcache_pkg::word_t wdata, input logic pte_a, input logic pte_d);
        logic accepted;
        logic answered;
        int cycles;
        req = '{valid: 1'b1, wen: wen, addr: addr, wdata: wdata, pte_a: pte_a, pte_d: pte_d};
        accepted = 1'b0;
        cycles = 0;
        while (!accepted && cycles < 200) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #10;
            cycles++;
        end
        req.valid = 1'b0;
        seen = '0;
        latency = 0;
        if (!accepted) begin
            $display("request to %h was never accepted", addr);
            timeout_errors++;
            return;
        end
        answered = 1'b0;
        while (!answered && latency < 200) begin
            @(negedge clk);
            latency++;
            if (resp.valid) begin
                answered = 1'b1;
                seen = resp;
            end
        end
        @(posedge clk);
        #10;
        if (!answered) begin
            $display("no response to the request at %h", addr);
            timeout_errors++;
        end
    endtask

    task automatic run_flush(input int expected_writes);
        int writes;
        int cycles;
        writes = write_count;
        flush = 1'b1;
        @(posedge clk);
        #10;
        flush = 1'b0;
        cycles = 0;
        while (!clean && cycles < 500) begin
            @(negedge clk);
            cycles++;
        end
        if (!clean) begin
            $display("clean did not rise after the flush");
            timeout_errors++;
        end
        @(posedge clk);
        #10;
        check_count("flush bus writes", write_count - writes, expected_writes);
    endtask

    task automatic check_reset_state();
        check_flag("req_ready", req_ready, 1'b1);
        check_flag("clean", clean, 1'b1);
        check_flag("resp.valid", resp.valid, 1'b0);
        check_flag("bus_req.valid", bus_req.valid, 1'b0);
    endtask

    task automatic test_read_miss_hit();
        int reads;
        reads = read_count;
        access(32'h0000_0010, 1'b0, '0, 1'b0, 1'b0);
        check_resp("miss resp", seen, make_resp(mem_pattern(32'h10), 1'b0), 1'b1);
        check_count("miss bus reads", read_count - reads, 1);
        access(32'h0000_0010, 1'b0, '0, 1'b0, 1'b0);
        check_resp("hit resp", seen, make_resp(mem_pattern(32'h10), 1'b0), 1'b1);
        check_count("hit bus reads", read_count - reads, 1);
        check_count("hit latency", latency, 1);
    endtask

    task automatic test_write_hit();
        int writes;
        writes = write_count;
        access(32'h0000_0010, 1'b1, 32'hdead_beef, 1'b0, 1'b0);
        check_resp("write hit resp", seen, make_resp('0, 1'b0), 1'b0);
        check_count("write hit latency", latency, 1);
        access(32'h0000_0010, 1'b0, '0, 1'b0, 1'b0);
        check_resp("read after write", seen, make_resp(32'hdead_beef, 1'b0), 1'b1);
        check_word("mem[4]", bus_mem.mem[4], shadow[4]);
        check_count("write hit bus writes", write_count - writes, 0);
        check_flag("clean", clean, 1'b0);
    endtask

    // same index as 0x10, different tag
    task automatic test_dirty_eviction();
        int writes;
        writes = write_count;
        access(32'h0000_0050, 1'b0, '0, 1'b0, 1'b0);
        check_count("eviction bus writes", write_count - writes, 1);
        check_bus_write(last_write, '{valid: 1'b1, wen: 1'b1, addr: 32'h10, wdata: 32'hdead_beef});
        shadow[4] = 32'hdead_beef;
        check_resp("eviction resp", seen, make_resp(mem_pattern(32'h50), 1'b0), 1'b1);
    endtask

    // accessed flag is bit 6, dirty flag bit 7
    task automatic test_pte_update();
        access(32'h0000_0020, 1'b0, '0, 1'b1, 1'b0);
        check_resp("pte_a miss resp", seen, make_resp(mem_pattern(32'h20) | 32'h40, 1'b0), 1'b1);
        access(32'h0000_0020, 1'b0, '0, 1'b1, 1'b1);
        check_resp("pte_d hit resp", seen, make_resp(mem_pattern(32'h20) | 32'hc0, 1'b0), 1'b1);
        access(32'h0000_0024, 1'b0, '0, 1'b1, 1'b1);
        check_resp("pte_d miss resp", seen, make_resp(mem_pattern(32'h24) | 32'hc0, 1'b0), 1'b1);
        shadow[8] = mem_pattern(32'h20) | 32'hc0;
        shadow[9] = mem_pattern(32'h24) | 32'hc0;
        run_flush(2);
        check_word("mem[8]", bus_mem.mem[8], shadow[8]);
        check_word("mem[9]", bus_mem.mem[9], shadow[9]);
    endtask

    task automatic test_bus_error();
        int reads;
        reads = read_count;
        access(32'hf000_0030, 1'b0, '0, 1'b0, 1'b0);
        check_resp("error resp", seen, make_resp('0, 1'b1), 1'b0);
        access(32'hf000_0030, 1'b0, '0, 1'b0, 1'b0);
        check_resp("repeated error resp", seen, make_resp('0, 1'b1), 1'b0);
        check_count("error bus reads", read_count - reads, 2);
    endtask

    // write misses to indices 0 to 3, then flush everything
    task automatic test_flush();
        dcache_pkg::addr_t addrs [4];
        dcache_pkg::word_t data;
        int writes;
        addrs = '{32'h0000_0100, 32'h0000_0144, 32'h0000_0088, 32'h0000_03cc};
        writes = write_count;
        for (int i = 0; i < 4; i++) begin
            data = addrs[i] ^ 32'h3c3c_a5a5;
            access(addrs[i], 1'b1, data, 1'b0, 1'b0);
            check_resp("write miss resp", seen, make_resp('0, 1'b0), 1'b0);
            check_count("write miss latency", latency, 1);
            shadow[addrs[i][9:2]] = data;
        end
        check_count("write miss bus writes", write_count - writes, 0);
        run_flush(4);
        for (int i = 0; i < 256; i++) begin
            check_word($sformatf("mem[%0d]", i), bus_mem.mem[i], shadow[i]);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        flush = 1'b0;
        value_errors = 0;
        timeout_errors = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = mem_pattern(dcache_pkg::addr_t'(i) << 2);
        end
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_reset_state();
        test_read_miss_hit();
        test_write_hit();
        test_dirty_eviction();
        test_pte_update();
        test_bus_error();
        test_flush();
        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
dv/bus_memory.sv
dv/tb_dcache.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dcache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
